/* compile.f */
+incdir+test
hdl/ex_pkg.sv
hdl/ex_decode.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_result.sv
hdl/ex_stage.sv
test/tb_ex_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_ex_stage
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Exit status of the simulation is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* test/tb_ex_ref.svh */
// Reference model of the execute stage giving expected ALU, multiply and branch results

`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

// Compare outcome, only branch and set-less-than operators give a 1
function automatic logic ref_cmp(input alu_op_e op, input logic [XLEN-1:0] a,
                                 input logic [XLEN-1:0] b);
  case (op)
    ALU_EQ:           return a == b;
    ALU_NE:           return a != b;
    ALU_LT, ALU_SLT:  return $signed(a) < $signed(b);
    ALU_GE:           return $signed(a) >= $signed(b);
    ALU_LTU, ALU_SLTU: return a < b;
    ALU_GEU:          return a >= b;
    default:          return 1'b0;
  endcase
endfunction

// RV32I integer result, shift amount is the low 5 bits of b
function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << sh;
    ALU_SRL: return a >> sh;
    ALU_SRA: return $signed(a) >>> sh;
    default: return {{(XLEN-1){1'b0}}, ref_cmp(op, a, b)};
  endcase
endfunction

// RV32M multiply, 64-bit product of the extended factors
function automatic logic [XLEN-1:0] ref_mul(input mul_op_e op, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
  logic [2*XLEN-1:0] wide_a;
  logic [2*XLEN-1:0] wide_b;
  logic [2*XLEN-1:0] prod;
  wide_a = {{XLEN{(op == MUL_HSS || op == MUL_HSU) && a[XLEN-1]}}, a};
  wide_b = {{XLEN{(op == MUL_HSS) && b[XLEN-1]}}, b};
  prod   = wide_a * wide_b;
  return (op == MUL_LO) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
endfunction

// Branch outcome, constant-time mode always redirects
function automatic branch_t ref_branch(input id_ex_t instr, input ctrl_t ctl,
                                       input fetch_pc_t fpc);
  branch_t br;
  logic    cmp;
  cmp         = ref_cmp(instr.alu_op, instr.operand_a, instr.operand_b);
  br.decision = cmp;
  br.target   = instr.operand_c;
  if (ctl.data_ind_timing) begin
    br.decision = 1'b1;
    // Not taken means the next sequential PC, from ID if it holds one
    if (!cmp) begin
      br.target = fpc.id_valid ? fpc.id_pc : fpc.if_pc;
    end
  end
  return br;
endfunction

`endif

/* test/tb_ex_stage.sv */
// Testbench for the execute stage with random stimulus, result queue and ordered checks

`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;

  import ex_pkg::*;

  `include "tb_ex_ref.svh"

  localparam int N_ALU    = 300;
  localparam int N_MUL    = 200;
  localparam int N_BR     = 60;
  localparam int N_ILL    = 4;
  localparam int N_TOTAL  = N_ALU + N_MUL + 2 * N_BR + N_ILL + 4;
  localparam int TIMEOUT_CYCLES = N_TOTAL * 8 + 100;
  localparam time DRIVE_DLY     = 2;

  localparam int KIND_ALU = 0;
  localparam int KIND_MUL = 1;
  localparam int KIND_BR  = 2;
  localparam int KIND_ILL = 3;

  localparam alu_op_e BRANCH_OPS [6] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

  logic      clk;
  logic      rst_n;
  id_ex_t    id_ex;
  ctrl_t     ctrl;
  fetch_pc_t fetch_pc;
  logic      wb_ready;
  logic      ex_ready;
  logic      ex_valid;
  branch_t   branch;
  ex_wb_t    ex_wb;

  // Expected EX/WB contents in issue order
  ex_wb_t      exp_q[$];
  int unsigned cycle_cnt;
  bit          bp_on;

  ex_stage dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_ex_i    (id_ex),
    .ctrl_i     (ctrl),
    .fetch_pc_i (fetch_pc),
    .wb_ready_i (wb_ready),
    .ex_ready_o (ex_ready),
    .ex_valid_o (ex_valid),
    .branch_o   (branch),
    .ex_wb_o    (ex_wb)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("TB FAILED");
    $fatal(1, reason);
  endtask

  task automatic check_ex_wb(input ex_wb_t got, input ex_wb_t want);
    string field;
    field = "";
    if (got.instr_valid !== want.instr_valid) field = "instr_valid";
    else if (got.rf_we !== want.rf_we) field = "rf_we";
    else if (got.pc !== want.pc) field = "pc";
    else if (got.illegal_insn !== want.illegal_insn) field = "illegal_insn";
    else if (got.branch_taken !== want.branch_taken) field = "branch_taken";
    // Register file fields only matter for writing instructions
    else if (want.rf_we && got.rf_waddr !== want.rf_waddr) field = "rf_waddr";
    else if (want.rf_we && got.rf_wdata !== want.rf_wdata) field = "rf_wdata";
    if (field != "") begin
      $display("Error: %0t ns: ex_wb_o.%s mismatch, got %h expected %h",
               $time, field, got, want);
      abort_run("EX/WB result mismatch");
    end
  endtask

  task automatic check_branch(input branch_t got, input branch_t want);
    if (got !== want) begin
      $display("Error: %0t ns: branch_o got decision %b target %h, expected %b %h",
               $time, got.decision, got.target, want.decision, want.target);
      abort_run("branch outcome mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("Error: %0t ns: %s is %b, expected %b", $time, what, got, want);
      abort_run("handshake flag mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic id_ex_t random_instr(input int kind);
    id_ex_t instr;
    instr             = '0;
    instr.instr_valid = 1'b1;
    instr.alu_op      = ALU_ADD;
    instr.operand_a   = $urandom;
    instr.operand_b   = $urandom;
    instr.operand_c   = $urandom & 32'hffff_fffc;
    instr.pc          = $urandom & 32'hffff_fffc;
    instr.rf_waddr    = 5'($urandom);
    instr.rf_we       = 1'b1;
    case (kind)
      KIND_ALU: begin
        instr.alu_en = 1'b1;
        instr.alu_op = alu_op_e'(4'($urandom));
        instr.rf_we  = ($urandom_range(7, 0) != 0);
      end
      KIND_MUL: begin
        instr.mul_en = 1'b1;
        instr.mul_op = mul_op_e'(2'($urandom));
      end
      KIND_BR: begin
        instr.alu_en = 1'b1;
        instr.alu_op = BRANCH_OPS[3'($urandom_range(5, 0))];
        instr.rf_we  = 1'b0;
        // Equal operands now and then so EQ and NE both resolve either way
        if ($urandom_range(3, 0) == 0) instr.operand_b = instr.operand_a;
      end
      default: begin
        instr.illegal_insn = 1'b1;
        instr.rf_we        = 1'b0;
      end
    endcase
    return instr;
  endfunction

  function automatic fetch_pc_t random_fetch_pc();
    fetch_pc_t fpc;
    fpc.id_valid = 1'($urandom);
    fpc.id_pc    = $urandom & 32'hffff_fffc;
    fpc.if_pc    = $urandom & 32'hffff_fffc;
    return fpc;
  endfunction

  // WB stalls about 30% of cycles when back-pressure is on
  task automatic update_wb_ready();
    wb_ready = bp_on ? ($urandom_range(99, 0) >= 30) : 1'b1;
  endtask

  // Present one instruction and hold it until EX takes it
  task automatic send(input id_ex_t instr, input ctrl_t ctl, input fetch_pc_t fpc);
    ex_wb_t  want;
    branch_t br;
    br                = ref_branch(instr, ctl, fpc);
    want.instr_valid  = 1'b1;
    want.rf_we        = instr.rf_we;
    want.rf_waddr     = instr.rf_waddr;
    want.rf_wdata     = instr.mul_en ? ref_mul(instr.mul_op, instr.operand_a, instr.operand_b)
                                     : ref_alu(instr.alu_op, instr.operand_a, instr.operand_b);
    want.pc           = instr.pc;
    want.illegal_insn = instr.illegal_insn;
    want.branch_taken = br.decision;
    exp_q.push_back(want);
    id_ex    = instr;
    ctrl     = ctl;
    fetch_pc = fpc;
    update_wb_ready();
    @(negedge clk);
    while (!ex_ready) begin
      @(posedge clk);
      #DRIVE_DLY;
      update_wb_ready();
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Killed instruction frees EX at once and never reaches WB
  task automatic send_killed(input id_ex_t instr);
    id_ex        = instr;
    ctrl         = '0;
    ctrl.kill_ex = 1'b1;
    fetch_pc     = random_fetch_pc();
    @(negedge clk);
    check_flag(ex_ready, 1'b1, "ex_ready_o under kill");
    check_flag(ex_valid, 1'b0, "ex_valid_o under kill");
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Halt stalls EX for a few cycles, then the instruction goes through
  task automatic send_halted(input id_ex_t instr, input int cycles);
    fetch_pc_t fpc;
    fpc          = random_fetch_pc();
    id_ex        = instr;
    ctrl         = '0;
    ctrl.halt_ex = 1'b1;
    fetch_pc     = fpc;
    repeat (cycles) begin
      @(negedge clk);
      check_flag(ex_ready, 1'b0, "ex_ready_o under halt");
      check_flag(ex_valid, 1'b0, "ex_valid_o under halt");
      @(posedge clk);
      #DRIVE_DLY;
    end
    send(instr, '0, fpc);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Comparing process at the falling edge where outputs have settled
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bit     load_pending;
    ex_wb_t want;
    load_pending = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        load_pending = 1'b0;
      end else begin
        // Register loaded at the last edge
        if (load_pending) begin
          if (exp_q.size() == 0) begin
            abort_run("EX/WB loaded an instruction that was never issued");
          end
          want = exp_q.pop_front();
          check_ex_wb(ex_wb, want);
        end
        if (!wb_ready && ex_ready && !ctrl.kill_ex) begin
          $display("Error: %0t ns: ex_ready_o is high while wb_ready_i is low", $time);
          abort_run("back-pressure ignored");
        end
        load_pending = ex_valid && wb_ready;
        if (load_pending) begin
          check_branch(branch, ref_branch(id_ex, ctrl, fetch_pc));
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    abort_run("timeout: pipeline stopped accepting instructions");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ctrl_t ctl;
    void'($urandom(32'hc1c7_288d));
    rst_n      = 1'b0;
    id_ex      = '0;
    ctrl       = '0;
    fetch_pc   = '0;
    wb_ready   = 1'b1;
    bp_on      = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag(ex_wb.instr_valid, 1'b0, "ex_wb_o.instr_valid after reset");
    check_flag(ex_wb.rf_we, 1'b0, "ex_wb_o.rf_we after reset");
    @(posedge clk);
    #DRIVE_DLY;

    // ALU stream with WB always ready
    repeat (N_ALU) send(random_instr(KIND_ALU), '0, random_fetch_pc());

    // Multiplies under random WB stalls
    bp_on = 1'b1;
    repeat (N_MUL) send(random_instr(KIND_MUL), '0, random_fetch_pc());
    bp_on = 1'b0;

    // Plain and constant-time branches
    ctl = '0;
    repeat (N_BR) send(random_instr(KIND_BR), ctl, random_fetch_pc());
    ctl.data_ind_timing = 1'b1;
    repeat (N_BR) send(random_instr(KIND_BR), ctl, random_fetch_pc());

    send_killed(random_instr(KIND_ALU));
    send_killed(random_instr(KIND_MUL));
    send_halted(random_instr(KIND_ALU), 5);
    send_halted(random_instr(KIND_MUL), 3);

    // Exceptions from ID pass straight through
    repeat (N_ILL) send(random_instr(KIND_ILL), '0, random_fetch_pc());

    id_ex = '0;
    ctrl  = '0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);
    // Idle cycles with WB ready leave only bubbles in EX/WB
    if (ex_wb.instr_valid !== 1'b0) begin
      $display("Error: %0t ns: ex_wb_o.instr_valid is %b, expected 0 with EX idle",
               $time, ex_wb.instr_valid);
      abort_run("EX/WB did not load a bubble");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
// Execute stage top level joining decode, ALU, multiplier and result register

`timescale 1ns/100ps
`default_nettype none

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::id_ex_t    id_ex_i,
  input  ex_pkg::ctrl_t     ctrl_i,
  input  ex_pkg::fetch_pc_t fetch_pc_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o,
  output ex_pkg::branch_t   branch_o,
  output ex_pkg::ex_wb_t    ex_wb_o
);

  import ex_pkg::*;

  logic            mul_start;
  logic            mul_valid;
  logic            mul_ready;
  logic [XLEN-1:0] mul_result;
  logic [XLEN-1:0] alu_result;
  logic            cmp_result;

  // Qualification and stage handshake
  ex_decode decode_i (
    .id_ex_i     (id_ex_i),
    .ctrl_i      (ctrl_i),
    .mul_valid_i (mul_valid),
    .mul_ready_i (mul_ready),
    .mul_start_o (mul_start),
    .ex_valid_o  (ex_valid_o),
    .ex_ready_o  (ex_ready_o)
  );

  // ALU and multiplier see the same operands
  ex_alu alu_i (
    .op_i         (id_ex_i.alu_op),
    .operand_a_i  (id_ex_i.operand_a),
    .operand_b_i  (id_ex_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  ex_mult mult_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_i     (id_ex_i.mul_op),
    .op_a_i   (id_ex_i.operand_a),
    .op_b_i   (id_ex_i.operand_b),
    .valid_i  (mul_start),
    .ready_i  (wb_ready_i),
    .result_o (mul_result),
    .valid_o  (mul_valid),
    .ready_o  (mul_ready)
  );

  // Branch outcome and EX/WB register
  ex_result result_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex_i      (id_ex_i),
    .alu_result_i (alu_result),
    .mul_result_i (mul_result),
    .cmp_result_i (cmp_result),
    .ex_valid_i   (ex_valid_o),
    .wb_ready_i   (wb_ready_i),
    .ctrl_i       (ctrl_i),
    .fetch_pc_i   (fetch_pc_i),
    .branch_o     (branch_o),
    .ex_wb_o      (ex_wb_o)
  );

endmodule

`default_nettype wire

/* hdl/ex_result.sv */
// Execute result stage with write-data select, branch resolution and EX/WB register

`timescale 1ns/100ps
`default_nettype none

module ex_result (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::id_ex_t          id_ex_i,
  input  logic [ex_pkg::XLEN-1:0] alu_result_i,
  input  logic [ex_pkg::XLEN-1:0] mul_result_i,
  input  logic                    cmp_result_i,
  input  logic                    ex_valid_i,
  input  logic                    wb_ready_i,
  input  ex_pkg::ctrl_t           ctrl_i,
  input  ex_pkg::fetch_pc_t       fetch_pc_i,
  output ex_pkg::branch_t         branch_o,
  output ex_pkg::ex_wb_t          ex_wb_o
);

  import ex_pkg::*;

  logic [XLEN-1:0]       rf_wdata;
  logic                  accept;
  logic                  instr_valid_q;
  logic                  rf_we_q;
  logic [REG_ADDR_W-1:0] rf_waddr_q;
  logic [XLEN-1:0]       rf_wdata_q;
  logic [XLEN-1:0]       pc_q;
  logic                  illegal_q;
  logic                  taken_q;

  // Write data, unit picked by the enable
  assign rf_wdata = id_ex_i.mul_en ? mul_result_i : alu_result_i;

  ////////////////////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (ctrl_i.data_ind_timing) begin
      // Always redirect, so timing does not depend on the compare
      branch_o.decision = 1'b1;
      if (cmp_result_i) begin
        branch_o.target = id_ex_i.operand_c;
      end else if (fetch_pc_i.id_valid) begin
        // Not taken, resume at the instruction in ID
        branch_o.target = fetch_pc_i.id_pc;
      end else begin
        branch_o.target = fetch_pc_i.if_pc;
      end
    end else begin
      branch_o.decision = cmp_result_i;
      branch_o.target   = id_ex_i.operand_c;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////////////////////////////////////////

  assign accept = ex_valid_i && wb_ready_i;

  // Control part
  // WB ready with nothing valid loads a bubble, WB stalled holds
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
      rf_we_q       <= 1'b0;
    end else if (accept) begin
      instr_valid_q <= 1'b1;
      rf_we_q       <= id_ex_i.rf_we;
    end else if (wb_ready_i) begin
      instr_valid_q <= 1'b0;
    end
  end

  // Payload part, only moves on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      // Register file fields only toggle for writing instructions
      if (id_ex_i.rf_we) begin
        rf_waddr_q <= id_ex_i.rf_waddr;
        rf_wdata_q <= rf_wdata;
      end
      pc_q      <= id_ex_i.pc;
      illegal_q <= id_ex_i.illegal_insn;
      taken_q   <= branch_o.decision;
    end
  end

  assign ex_wb_o.instr_valid  = instr_valid_q;
  assign ex_wb_o.rf_we        = rf_we_q;
  assign ex_wb_o.rf_waddr     = rf_waddr_q;
  assign ex_wb_o.rf_wdata     = rf_wdata_q;
  assign ex_wb_o.pc           = pc_q;
  assign ex_wb_o.illegal_insn = illegal_q;
  assign ex_wb_o.branch_taken = taken_q;

endmodule

`default_nettype wire

/* hdl/ex_mult.sv */
// Two-cycle 32x32 multiplier with valid/ready handshake and result hold

`timescale 1ns/100ps
`default_nettype none

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::mul_op_e         op_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  logic                    valid_i,
  input  logic                    ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    valid_o,
  output logic                    ready_o
);

  import ex_pkg::*;

  logic                   a_signed;
  logic                   b_signed;
  logic                   valid_q;
  mul_op_e                op_q;
  logic signed [XLEN:0]   op_a_q;
  logic signed [XLEN:0]   op_b_q;
  logic signed [2*XLEN+1:0] product;

  // MULHSU takes a signed, MULH both, MULHU neither
  assign a_signed = (op_i == MUL_HSS) || (op_i == MUL_HSU);
  assign b_signed = (op_i == MUL_HSS);

  // Busy flag, set on accept, cleared on handoff
  // Dropping valid_i while busy abandons the item
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (!valid_q && valid_i) begin
      valid_q <= 1'b1;
    end else if (valid_q && (ready_i || !valid_i)) begin
      valid_q <= 1'b0;
    end
  end

  // Operands extended to 33 bits at accept
  always_ff @(posedge clk) begin
    if (!valid_q && valid_i) begin
      op_q   <= op_i;
      op_a_q <= {a_signed & op_a_i[XLEN-1], op_a_i};
      op_b_q <= {b_signed & op_b_i[XLEN-1], op_b_i};
    end
  end

  // Second cycle, full product then word select
  assign product  = op_a_q * op_b_q;
  assign result_o = (op_q == MUL_LO) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
  assign valid_o  = valid_q;

  // Not ready while a new item is being taken in, or while WB stalls
  assign ready_o = ready_i && (valid_q || !valid_i);

endmodule

`default_nettype wire

/* hdl/ex_alu.sv */
// Single-cycle integer ALU with a separate branch compare result

`timescale 1ns/100ps
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_op_e           op_i,
  input  logic [ex_pkg::XLEN-1:0]   operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]   operand_b_i,
  output logic [ex_pkg::XLEN-1:0]   result_o,
  output logic                      cmp_result_o
);

  import ex_pkg::*;

  logic               is_signed;
  logic [XLEN:0]      sub_a;
  logic [XLEN:0]      sub_b;
  logic [XLEN:0]      diff;
  logic               less;
  logic               equal;
  logic [XLEN-1:0]    sum;
  logic [SHAMT_W-1:0] shamt;

  ////////////////////////////////////////////////////////////////////////////
  // Shared subtractor
  ////////////////////////////////////////////////////////////////////////////

  // Signed compares extend with the sign bit, unsigned ones with zero
  assign is_signed = (op_i == ALU_SLT) || (op_i == ALU_LT) || (op_i == ALU_GE);

  assign sub_a = {is_signed & operand_a_i[XLEN-1], operand_a_i};
  assign sub_b = {is_signed & operand_b_i[XLEN-1], operand_b_i};

  // One extra bit so the top bit is the true less-than
  assign diff  = sub_a - sub_b;
  assign less  = diff[XLEN];
  assign equal = (diff == '0);

  assign sum   = operand_a_i + operand_b_i;
  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Compare outcome for branches and set-less-than
  always_comb begin
    case (op_i)
      ALU_EQ:                    cmp_result_o = equal;
      ALU_NE:                    cmp_result_o = !equal;
      ALU_LT, ALU_LTU:           cmp_result_o = less;
      ALU_SLT, ALU_SLTU:         cmp_result_o = less;
      ALU_GE, ALU_GEU:           cmp_result_o = !less;
      default:                   cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff[XLEN-1:0];
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      ALU_SRA: result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compares give a 0 or 1 word
      default: result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_decode.sv */
// Execute stage decode qualifying the instruction and generating stage valid and ready

`timescale 1ns/100ps
`default_nettype none

module ex_decode (
  input  ex_pkg::id_ex_t id_ex_i,
  input  ex_pkg::ctrl_t  ctrl_i,
  input  logic           mul_valid_i,
  input  logic           mul_ready_i,
  output logic           mul_start_o,
  output logic           ex_valid_o,
  output logic           ex_ready_o
);

  logic instr_ok;
  logic prev_exception;
  logic unit_valid;

  // Instruction survives only without kill or halt
  assign instr_ok = id_ex_i.instr_valid && !ctrl_i.kill_ex && !ctrl_i.halt_ex;

  // A killed or halted multiply never starts
  assign mul_start_o = id_ex_i.mul_en && instr_ok;

  // Illegal instruction from ID needs no unit, it just flows to WB
  assign prev_exception = id_ex_i.illegal_insn && id_ex_i.instr_valid;

  // ALU result is there in the same cycle
  // Multiply result only once the multiplier says so
  assign unit_valid = id_ex_i.alu_en ||
                      (id_ex_i.mul_en && mul_valid_i) ||
                      prev_exception;

  assign ex_valid_o = unit_valid && instr_ok;

  // Kill always frees the stage
  // Otherwise the multiplier ready already carries WB back-pressure
  assign ex_ready_o = ctrl_i.kill_ex || (mul_ready_i && !ctrl_i.halt_ex);

endmodule

`default_nettype wire

/* hdl/ex_pkg.sv */
// Execute stage package with widths, operator encodings and pipeline payload types

`default_nettype none

package ex_pkg;

  // Data path and register file widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned SHAMT_W    = $clog2(XLEN);

  ////////////////////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////////////////////

  // ALU operators, arithmetic and logic first, then the compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operators, low word or one of three high-word signednesses
  typedef enum logic [1:0] {
    MUL_LO  = 2'b00,
    MUL_HSS = 2'b01,
    MUL_HUU = 2'b10,
    MUL_HSU = 2'b11
  } mul_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline payloads
  ////////////////////////////////////////////////////////////////////////////

  // ID/EX register contents
  typedef struct packed {
    logic                  instr_valid;
    logic                  alu_en;
    logic                  mul_en;
    logic                  illegal_insn;
    logic                  rf_we;
    alu_op_e               alu_op;
    mul_op_e               mul_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;    // Branch target
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rf_waddr;
  } id_ex_t;

  // Controller requests toward EX
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
    logic data_ind_timing;
  } ctrl_t;

  // PCs held by the earlier stages
  typedef struct packed {
    logic            id_valid;
    logic [XLEN-1:0] id_pc;
    logic [XLEN-1:0] if_pc;
  } fetch_pc_t;

  // Branch outcome toward IF
  typedef struct packed {
    logic            decision;
    logic [XLEN-1:0] target;
  } branch_t;

  // EX/WB register contents
  typedef struct packed {
    logic                  instr_valid;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic [XLEN-1:0]       pc;
    logic                  illegal_insn;
    logic                  branch_taken;
  } ex_wb_t;

endpackage

`default_nettype wire
